/* hw/core_pkg.sv */
package core_pkg;

	localparam int WORD_W      = 32;
	localparam int PTR_W       = 30; // Word address
	localparam int REG_COUNT   = 16;
	localparam int QUEUE_DEPTH = 2;  // Also the sender's starting credits

	localparam logic [3:0] LINK_REG = 4'd14;

	localparam logic [3:0] ALU_AND = 4'd0;
	localparam logic [3:0] ALU_EOR = 4'd1;
	localparam logic [3:0] ALU_SUB = 4'd2;
	localparam logic [3:0] ALU_ADD = 4'd4;
	localparam logic [3:0] ALU_ADC = 4'd5;
	localparam logic [3:0] ALU_ORR = 4'd12;
	localparam logic [3:0] ALU_MOV = 4'd13;
	localparam logic [3:0] ALU_BIC = 4'd14;

	localparam logic [1:0] SHIFT_LSL = 2'd0;
	localparam logic [1:0] SHIFT_LSR = 2'd1;
	localparam logic [1:0] SHIFT_ASR = 2'd2;
	localparam logic [1:0] SHIFT_ROR = 2'd3;

	// Upper 15 bits are common to both views
	typedef union packed {
		struct packed {
			logic [3:0]  opcode;
			logic        is_imm;
			logic        shift_by_reg;
			logic [3:0]  rd;
			logic [3:0]  rn;
			logic        set_flags;
			logic [4:0]  reserved;
			logic [11:0] imm12;
		} imm_view;
		struct packed {
			logic [3:0]  opcode;
			logic        is_imm;
			logic        shift_by_reg;
			logic [3:0]  rd;
			logic [3:0]  rn;
			logic        set_flags;
			logic [3:0]  rm;
			logic [3:0]  rs;
			logic [1:0]  shift_type;
			logic [5:0]  shift_imm;
			logic        reserved;
		} reg_view;
	} insn_word_u;

endpackage

/* hw/core_insn_queue.sv */
`timescale 1ns/1ps

module core_insn_queue
	import core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       insn_valid,
	input  insn_word_u insn,
	input  logic       pop,
	output insn_word_u head,
	output logic       head_valid,
	output logic       credit_return
);

	insn_word_u mem [QUEUE_DEPTH];

	logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(QUEUE_DEPTH+1)-1:0] count;

	assign head       = mem[rd_ptr];
	assign head_valid = count != '0;

	always_ff @(posedge clk)
		if (insn_valid)
			mem[wr_ptr] <= insn;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop; // One credit back per popped entry
			if (insn_valid)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({insn_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* hw/core_decode.sv */
`timescale 1ns/1ps

module core_decode
	import core_pkg::*;
(
	input  insn_word_u  head,
	output logic [3:0]  dec_alu_op,
	output logic [11:0] dec_imm,
	output logic [5:0]  dec_shift_imm,
	output logic        dec_is_imm,
	output logic        dec_shift_by_reg,
	output logic        dec_shr,
	output logic        dec_ror,
	output logic        dec_sign_extend,
	output logic        dec_put_carry,
	output logic        dec_undefined
);

	logic logical_op;

	assign dec_alu_op    = head.imm_view.opcode;
	assign dec_is_imm    = head.imm_view.is_imm;
	assign dec_put_carry = logical_op && head.imm_view.set_flags;

	always_comb begin
		dec_imm          = '0;
		dec_shift_imm    = '0;
		dec_shift_by_reg = 1'b0;
		dec_shr          = 1'b0;
		dec_ror          = 1'b0;
		dec_sign_extend  = 1'b0;

		if (dec_is_imm) begin
			dec_imm = head.imm_view.imm12; // No shift on an immediate
		end else begin
			dec_shift_imm    = head.reg_view.shift_imm;
			dec_shift_by_reg = head.reg_view.shift_by_reg;
			case (head.reg_view.shift_type)
				SHIFT_LSL: ;
				SHIFT_LSR: dec_shr = 1'b1;
				SHIFT_ASR: begin
					dec_shr         = 1'b1;
					dec_sign_extend = 1'b1;
				end
				SHIFT_ROR: dec_ror = 1'b1;
			endcase
		end
	end

	always_comb begin
		logical_op    = 1'b0;
		dec_undefined = 1'b0;
		case (dec_alu_op)
			ALU_AND, ALU_EOR, ALU_ORR, ALU_MOV, ALU_BIC: logical_op = 1'b1;
			ALU_SUB, ALU_ADD, ALU_ADC: ;
			default: dec_undefined = 1'b1;
		endcase
	end

endmodule

/* hw/core_control_cycle.sv */
`timescale 1ns/1ps

module core_control_cycle
	import core_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  insn_word_u       head,
	input  logic             head_valid,
	input  logic             dec_undefined,
	input  logic             trivial_shift,
	input  logic             data_snd_shift_by_reg,
	output logic             pop,
	output logic             cycle_issue,
	output logic             cycle_rd_indirect_shift,
	output logic             cycle_with_shift,
	output logic             cycle_exception,
	output logic             next_issue,
	output logic             next_rd_indirect_shift,
	output logic             next_with_shift,
	output logic             next_exception,
	output logic [PTR_W-1:0] pc,
	output logic [3:0]       ra_addr,
	output logic [3:0]       rb_addr,
	output logic [3:0]       wr_addr,
	output logic             wr_en,
	output logic             flags_en,
	output logic             result_valid,
	output logic             result_exception
);

	logic [3:0] rd_q, rm_q, rs_q;
	logic       set_flags_q, undefined_q;
	logic       idle, issue_plain, final_cycle;

	assign idle        = !(cycle_issue || cycle_rd_indirect_shift || cycle_with_shift ||
	                       cycle_exception);
	assign issue_plain = cycle_issue && !undefined_q && !data_snd_shift_by_reg;
	assign final_cycle = ((issue_plain || cycle_rd_indirect_shift) && trivial_shift) ||
	                     cycle_with_shift || cycle_exception;

	assign next_issue             = head_valid && (idle || final_cycle);
	assign next_rd_indirect_shift = cycle_issue && !undefined_q && data_snd_shift_by_reg;
	assign next_with_shift        = (issue_plain || cycle_rd_indirect_shift) && !trivial_shift;
	assign next_exception         = cycle_issue && undefined_q;
	assign pop                    = next_issue;

	assign rb_addr          = cycle_rd_indirect_shift ? rs_q : rm_q;
	assign wr_addr          = cycle_exception ? LINK_REG : rd_q;
	assign wr_en            = final_cycle;
	assign flags_en         = final_cycle && set_flags_q && !cycle_exception; // Exception keeps NZCV
	assign result_valid     = final_cycle;
	assign result_exception = cycle_exception;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle_issue             <= 1'b0;
			cycle_rd_indirect_shift <= 1'b0;
			cycle_with_shift        <= 1'b0;
			cycle_exception         <= 1'b0;
			pc                      <= '0;
			rd_q                    <= '0;
			ra_addr                 <= '0;
			rm_q                    <= '0;
			rs_q                    <= '0;
			set_flags_q             <= 1'b0;
			undefined_q             <= 1'b0;
		end else begin
			cycle_issue             <= next_issue;
			cycle_rd_indirect_shift <= next_rd_indirect_shift;
			cycle_with_shift        <= next_with_shift;
			cycle_exception         <= next_exception;
			if (final_cycle)
				pc <= pc + 1'b1; // Index of the instruction in flight
			if (next_issue) begin
				rd_q        <= head.reg_view.rd;
				ra_addr     <= head.reg_view.rn;
				rm_q        <= head.reg_view.rm;
				rs_q        <= head.reg_view.rs;
				set_flags_q <= head.reg_view.set_flags;
				undefined_q <= dec_undefined;
			end
		end
	end

endmodule

/* hw/core_control_data.sv */
`timescale 1ns/1ps

module core_control_data
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [3:0]        dec_alu_op,
	input  logic [11:0]       dec_imm,
	input  logic [5:0]        dec_shift_imm,
	input  logic              dec_is_imm,
	input  logic              dec_shift_by_reg,
	input  logic              dec_shr,
	input  logic              dec_ror,
	input  logic              dec_sign_extend,
	input  logic              dec_put_carry,
	input  logic [WORD_W-1:0] rd_value_a,
	input  logic [WORD_W-1:0] rd_value_b,
	input  logic [WORD_W-1:0] q_shifter,
	input  logic              c_shifter,
	input  logic              cycle_rd_indirect_shift,
	input  logic              cycle_with_shift,
	input  logic              cycle_exception,
	input  logic              next_issue,
	input  logic              next_rd_indirect_shift,
	input  logic              next_with_shift,
	input  logic              next_exception,
	input  logic [PTR_W-1:0]  pc,
	input  logic              flag_c,
	input  logic              flag_v,
	output logic [3:0]        alu,
	output logic [WORD_W-1:0] alu_a,
	output logic [WORD_W-1:0] alu_b,
	output logic [WORD_W-1:0] shifter_base,
	output logic [7:0]        shifter_shift,
	output logic              shifter_shr,
	output logic              shifter_ror,
	output logic              shifter_sign_extend,
	output logic              shifter_put_carry,
	output logic              c_in,
	output logic              v_in,
	output logic              trivial_shift,
	output logic              data_snd_shift_by_reg
);

	logic [WORD_W-1:0] saved_base;
	logic [11:0]       data_imm;
	logic [5:0]        data_shift_imm;
	logic              data_snd_is_imm;

	assign trivial_shift = shifter_shift == '0;
	assign shifter_base  = alu_b;

	always_comb begin
		if (cycle_rd_indirect_shift)
			shifter_shift = rd_value_b[7:0]; // Low byte of rs
		else
			shifter_shift = {2'b00, data_shift_imm};

		if (cycle_exception)
			alu_a = {pc, 2'b00};
		else
			alu_a = rd_value_a;

		if (cycle_rd_indirect_shift || cycle_with_shift)
			alu_b = saved_base;
		else if (data_snd_is_imm)
			alu_b = {{(WORD_W - 12){1'b0}}, data_imm};
		else
			alu_b = rd_value_b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu                   <= '0;
			c_in                  <= 1'b0;
			v_in                  <= 1'b0;
			saved_base            <= '0;
			data_imm              <= '0;
			data_shift_imm        <= '0;
			data_snd_is_imm       <= 1'b0;
			data_snd_shift_by_reg <= 1'b0;
			shifter_shr           <= 1'b0;
			shifter_ror           <= 1'b0;
			shifter_sign_extend   <= 1'b0;
			shifter_put_carry     <= 1'b0;
		end else if (next_issue) begin
			alu                   <= dec_alu_op;
			c_in                  <= flag_c; // Already includes this cycle's flag write
			v_in                  <= flag_v;
			data_imm              <= dec_imm;
			data_shift_imm        <= dec_shift_imm;
			data_snd_is_imm       <= dec_is_imm;
			data_snd_shift_by_reg <= dec_shift_by_reg;
			shifter_shr           <= dec_shr;
			shifter_ror           <= dec_ror;
			shifter_sign_extend   <= dec_sign_extend;
			shifter_put_carry     <= dec_put_carry;
		end else if (next_rd_indirect_shift) begin
			saved_base            <= rd_value_b; // rm, before the shift
			data_snd_shift_by_reg <= 1'b0;
		end else if (next_with_shift) begin
			c_in       <= c_shifter;
			saved_base <= q_shifter;
		end else if (next_exception) begin
			alu             <= ALU_ADD; // Return address pc*4 + 4
			data_imm        <= 12'd4;
			data_snd_is_imm <= 1'b1;
		end
	end

endmodule

/* hw/core_shifter.sv */
`timescale 1ns/1ps

module core_shifter
	import core_pkg::*;
(
	input  logic [WORD_W-1:0] base,
	input  logic [7:0]        shift,
	input  logic              shr,
	input  logic              ror,
	input  logic              sign_extend,
	input  logic              put_carry,
	input  logic              c_in,
	output logic [WORD_W-1:0] q,
	output logic              c_out
);

	logic [WORD_W:0]     lsl_wide;   // Carry on top
	logic [WORD_W+1:0]   shr_wide;   // Fill, base, carry
	logic [2*WORD_W-1:0] ror_wide;
	logic                c_last;

	always_comb begin
		lsl_wide = {1'b0, base} << shift;
		shr_wide = $signed({sign_extend & base[WORD_W-1], base, 1'b0}) >>> shift;
		ror_wide = {base, base} >> shift[4:0];

		if (ror) begin
			q      = ror_wide[WORD_W-1:0];
			c_last = q[WORD_W-1];
		end else if (shr) begin
			q      = shr_wide[WORD_W:1];
			c_last = shr_wide[0];
		end else begin
			q      = lsl_wide[WORD_W-1:0];
			c_last = lsl_wide[WORD_W];
		end

		c_out = (put_carry && shift != '0) ? c_last : c_in;
	end

endmodule

/* hw/core_alu.sv */
`timescale 1ns/1ps

module core_alu
	import core_pkg::*;
(
	input  logic [3:0]        op,
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	input  logic              c_in,
	input  logic              v_in,
	output logic [WORD_W-1:0] q,
	output logic [3:0]        nzcv
);

	logic [WORD_W:0] sum;
	logic [WORD_W-1:0] b_eff;
	logic carry_in, c, v, arith;

	always_comb begin
		arith    = 1'b1;
		b_eff    = b;
		carry_in = 1'b0;
		case (op)
			ALU_SUB: begin
				b_eff    = ~b;
				carry_in = 1'b1; // C set means no borrow
			end
			ALU_ADC: carry_in = c_in;
			ALU_ADD: ;
			default: arith = 1'b0;
		endcase

		sum = {1'b0, a} + {1'b0, b_eff} + {{WORD_W{1'b0}}, carry_in};

		case (op)
			ALU_AND: q = a & b;
			ALU_EOR: q = a ^ b;
			ALU_ORR: q = a | b;
			ALU_MOV: q = b;
			ALU_BIC: q = a & ~b;
			default: q = sum[WORD_W-1:0];
		endcase

		c = arith ? sum[WORD_W] : c_in;
		v = arith ? (a[WORD_W-1] == b_eff[WORD_W-1]) && (q[WORD_W-1] != a[WORD_W-1]) : v_in;
		nzcv = {q[WORD_W-1], q == '0, c, v};
	end

endmodule

/* hw/core_regfile.sv */
`timescale 1ns/1ps

module core_regfile
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [3:0]        ra_addr,
	input  logic [3:0]        rb_addr,
	input  logic [3:0]        wr_addr,
	input  logic              wr_en,
	input  logic              flags_en,
	input  logic [WORD_W-1:0] wr_data,
	input  logic [3:0]        nzcv_in,
	output logic [WORD_W-1:0] rd_value_a,
	output logic [WORD_W-1:0] rd_value_b,
	output logic [3:0]        flags
);

	logic [WORD_W-1:0] regs [REG_COUNT];
	logic [3:0]        flags_q;

	assign rd_value_a = regs[ra_addr];
	assign rd_value_b = regs[rb_addr];
	assign flags      = flags_en ? nzcv_in : flags_q; // Value after this edge

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
			flags_q <= '0;
		end else begin
			if (wr_en)
				regs[wr_addr] <= wr_data;
			if (flags_en)
				flags_q <= nzcv_in;
		end
	end

endmodule

/* hw/core_exec_top.sv */
`timescale 1ns/1ps

module core_exec_top
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              insn_valid,
	input  insn_word_u        insn,
	output logic              credit_return,
	output logic              result_valid,
	output logic [3:0]        result_rd,
	output logic [WORD_W-1:0] result_value,
	output logic [3:0]        result_flags,
	output logic              result_exception
);

	insn_word_u        head;
	logic              head_valid, pop;
	logic [3:0]        dec_alu_op;
	logic [11:0]       dec_imm;
	logic [5:0]        dec_shift_imm;
	logic              dec_is_imm, dec_shift_by_reg, dec_shr, dec_ror;
	logic              dec_sign_extend, dec_put_carry, dec_undefined;
	logic              cycle_issue, cycle_rd_indirect_shift, cycle_with_shift, cycle_exception;
	logic              next_issue, next_rd_indirect_shift, next_with_shift, next_exception;
	logic [PTR_W-1:0]  pc;
	logic [3:0]        ra_addr, rb_addr, wr_addr;
	logic              wr_en, flags_en;
	logic [WORD_W-1:0] rd_value_a, rd_value_b, q_shifter, alu_a, alu_b, shifter_base;
	logic [3:0]        alu, nzcv;
	logic [7:0]        shifter_shift;
	logic              shifter_shr, shifter_ror, shifter_sign_extend, shifter_put_carry;
	logic              c_shifter, c_in, v_in, trivial_shift, data_snd_shift_by_reg;

	assign result_rd = wr_addr;

	core_insn_queue queue0 (
		.clk, .rst_n, .insn_valid, .insn, .pop, .head, .head_valid, .credit_return
	);

	core_decode decode0 (
		.head, .dec_alu_op, .dec_imm, .dec_shift_imm, .dec_is_imm, .dec_shift_by_reg,
		.dec_shr, .dec_ror, .dec_sign_extend, .dec_put_carry, .dec_undefined
	);

	core_control_cycle cycle0 (
		.clk, .rst_n, .head, .head_valid, .dec_undefined, .trivial_shift,
		.data_snd_shift_by_reg, .pop, .cycle_issue, .cycle_rd_indirect_shift,
		.cycle_with_shift, .cycle_exception, .next_issue, .next_rd_indirect_shift,
		.next_with_shift, .next_exception, .pc, .ra_addr, .rb_addr, .wr_addr, .wr_en,
		.flags_en, .result_valid, .result_exception
	);

	core_control_data data0 (
		.clk, .rst_n, .dec_alu_op, .dec_imm, .dec_shift_imm, .dec_is_imm, .dec_shift_by_reg,
		.dec_shr, .dec_ror, .dec_sign_extend, .dec_put_carry, .rd_value_a, .rd_value_b,
		.q_shifter, .c_shifter, .cycle_rd_indirect_shift, .cycle_with_shift,
		.cycle_exception, .next_issue, .next_rd_indirect_shift, .next_with_shift,
		.next_exception, .pc, .flag_c(result_flags[1]), .flag_v(result_flags[0]), .alu,
		.alu_a, .alu_b, .shifter_base, .shifter_shift, .shifter_shr, .shifter_ror,
		.shifter_sign_extend, .shifter_put_carry, .c_in, .v_in, .trivial_shift,
		.data_snd_shift_by_reg
	);

	core_shifter shifter0 (
		.base(shifter_base), .shift(shifter_shift), .shr(shifter_shr), .ror(shifter_ror),
		.sign_extend(shifter_sign_extend), .put_carry(shifter_put_carry), .c_in,
		.q(q_shifter), .c_out(c_shifter)
	);

	core_alu alu0 (
		.op(alu), .a(alu_a), .b(alu_b), .c_in, .v_in, .q(result_value), .nzcv
	);

	core_regfile regs0 (
		.clk, .rst_n, .ra_addr, .rb_addr, .wr_addr, .wr_en, .flags_en,
		.wr_data(result_value), .nzcv_in(nzcv), .rd_value_a, .rd_value_b,
		.flags(result_flags)
	);

endmodule

/* dv/core_exec_tb.sv */
`timescale 1ns/1ps

module core_exec_tb
	import core_pkg::*;
();

	localparam int STIM_MAX = 128;

	logic              clk;
	logic              rst_n;
	logic              insn_valid;
	insn_word_u        insn;
	logic              credit_return;
	logic              result_valid;
	logic [3:0]        result_rd;
	logic [WORD_W-1:0] result_value;
	logic [3:0]        result_flags;
	logic              result_exception;

	logic [47:0]       stim [STIM_MAX]; // kind, rd, nzcv, exception, value or word
	insn_word_u        insn_list [$];
	logic [3:0]        exp_rd [$];
	logic [3:0]        exp_flags [$];
	logic [WORD_W-1:0] exp_value [$];
	logic              exp_exc [$];

	int seed        = 32'hf551;
	int cycles      = 0;
	int cycle_limit = 0;
	int credits;
	int results_seen;
	int n_results;

	core_exec_top dut0 (
		.clk, .rst_n, .insn_valid, .insn, .credit_return, .result_valid, .result_rd,
		.result_value, .result_flags, .result_exception
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [WORD_W-1:0] exp, act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s value: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flags(input string name, input logic [3:0] exp, act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s nzcv: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_reg(input string name, input logic [3:0] exp, act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s rd: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s exception: expected %b, actual %b", name, exp, act));
	endtask

	task automatic load_stim();
		logic [3:0] kind;
		for (int i = 0; i < STIM_MAX; i++)
			stim[i] = '0;
		$readmemh("dv/core_exec_stim.txt", stim);
		for (int i = 0; i < STIM_MAX; i++) begin
			kind = stim[i][47:44];
			if (kind == 4'h1) begin
				insn_list.push_back(stim[i][31:0]);
			end else if (kind == 4'h2) begin
				exp_rd.push_back(stim[i][43:40]);
				exp_flags.push_back(stim[i][39:36]);
				exp_exc.push_back(stim[i][32]);
				exp_value.push_back(stim[i][31:0]);
			end
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit)
			fail_run("Timeout: the DUT did not return all results in time");
	end

	// Results checked in program order
	always @(negedge clk) begin
		string name;
		if (rst_n && result_valid) begin
			if (exp_rd.size() == 0)
				fail_run("A result came out with no instruction outstanding");
			name = $sformatf("insn %0d", results_seen);
			check_reg(name, exp_rd.pop_front(), result_rd);
			check_value(name, exp_value.pop_front(), result_value);
			check_flags(name, exp_flags.pop_front(), result_flags);
			check_bit(name, exp_exc.pop_front(), result_exception);
			results_seen++;
		end
	end

	initial begin
		int gap;
		int sent;
		rst_n        = 1'b0;
		insn_valid   = 1'b0;
		insn         = '0;
		credits      = QUEUE_DEPTH;
		results_seen = 0;
		gap          = 0;
		sent         = 0;
		load_stim();
		n_results = exp_rd.size();
		if (insn_list.size() == 0 || n_results != insn_list.size())
			fail_run("The stimulus file is empty or its records do not pair up");
		cycle_limit = 20 * insn_list.size() + 100;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		while (results_seen < n_results) begin
			@(negedge clk);
			insn_valid = 1'b0;
			if (credit_return)
				credits++;
			if (credits > QUEUE_DEPTH)
				fail_run("More credits came back than instructions were sent");
			if (sent < insn_list.size()) begin
				if (gap > 0) begin
					gap--;
				end else if (credits > 0) begin
					insn       = insn_list[sent];
					insn_valid = 1'b1;
					credits--;
					sent++;
					gap = $unsigned($random(seed)) % 4; // Idle cycles before the next send
				end
			end
		end

		repeat (3) begin
			@(negedge clk);
			insn_valid = 1'b0;
			if (credit_return)
				credits++;
		end

		if (exp_rd.size() != 0) begin
			fail_run("Expected results are left over at the end of the run");
		end else if (credits != QUEUE_DEPTH) begin
			fail_run($sformatf("Only %0d of %0d credits came back", credits, QUEUE_DEPTH));
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* dv/core_exec_stim.txt */
// Kind 1: 1000 then the 32-bit instruction word
// Kind 2: 2, rd, nzcv, exception, then the 32-bit result value
1000D84200FF
2100000000FF
100028860100
2280FFFFFFFF
1000198400F0
26800000000F
100048CA0001
236000000000
100059060010
240000000110
1000C9460F00
250000000FFF
1000E9D600F0
270000000F0F
10000A0A0800
280000000800
1000D2424008
29A0FFFFFFF0
1000D2822082
2A200000007F
100042C52108
2B20000000FE
1000D3022190
2CA0FF000000
100043442000
2DA0000001FE
1000D8C00005
23A000000005
1000D9000020
24A000000020
1000D9400028
25A000000028
1000D5838000
26A0FF000000
1000D5C38680
270007F80000
1000D6038800
284000000000
1000D6438B00
29A0FFFFFFFF
1000D6838A80
2A4000000000
1000D6C38980
2BA0FF000000
100030000000
2EA10000005C
100058420000
210000000001
100028860001
226000000000
100058C60002
230000000004

/* project.f */
hw/core_pkg.sv
hw/core_insn_queue.sv
hw/core_decode.sv
hw/core_control_cycle.sv
hw/core_control_data.sv
hw/core_shifter.sv
hw/core_alu.sv
hw/core_regfile.sv
hw/core_exec_top.sv
dv/core_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module core_exec_tb -o core_exec_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_exec_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
fi

if grep -q "Finished with no errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
